// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_store_if.sv
      - rtl/dcache_store.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_top.sv
  - target: test
    files:
      - tests/dcache_mem_model.sv
      - tests/dcache_sva.sv
      - tests/tb_dcache.sv

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_read,
    input  logic                i_write,
    input  dcache_pkg::word_t   i_addr,
    input  dcache_pkg::word_t   i_wdata,
    input  dcache_pkg::stamp_t  i_instr_count,
    input  dcache_pkg::word_t   i_mem_rdata,
    output dcache_pkg::word_t   o_rdata,
    output logic                o_hit,
    output logic                o_busy,
    output logic                o_done,
    output dcache_pkg::word_t   o_mem_addr,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output dcache_pkg::word_t   o_mem_wdata,
    dcache_store_if.ctrl        store
);
    import dcache_pkg::*;

    dcache_state_e state_q;
    dcache_state_e state_d;

    word_t   addr_q;
    word_t   wdata_q;
    stamp_t  stamp_q;
    word_t   resp_q;
    word_t   fill_q [WORDS_PER_LINE];

    logic    idle;
    logic    filling;
    offset_t fill_off;
    offset_t req_off;

    assign idle    = (state_q == IDLE);
    assign req_off = addr_q[OFFSET_W-1:0];

    always_comb begin
        filling  = 1'b1;
        fill_off = '0;
        case (state_q)
            FILL0:   fill_off = offset_t'(0);
            FILL1:   fill_off = offset_t'(1);
            FILL2:   fill_off = offset_t'(2);
            FILL3:   fill_off = offset_t'(3);
            default: filling = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_read) begin
                    if (!store.hit) state_d = FILL0;   // hits stay in idle
                end else if (i_write) begin
                    state_d = WRITE;
                end
            end
            FILL0:   state_d = FILL1;
            FILL1:   state_d = FILL2;
            FILL2:   state_d = FILL3;
            FILL3:   state_d = RESPOND;
            RESPOND: state_d = IDLE;
            WRITE:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (idle && (i_read || i_write)) begin
            addr_q  <= i_addr;
            wdata_q <= i_wdata;
            stamp_q <= i_instr_count;
        end
        if (filling) begin
            fill_q[fill_off] <= i_mem_rdata;
        end
        // last word is still on the bus in FILL3
        if (state_q == FILL3) begin
            resp_q <= (req_off == offset_t'(WORDS_PER_LINE-1)) ? i_mem_rdata
                                                               : fill_q[req_off];
        end
    end

    assign store.lookup_addr = idle ? i_addr : addr_q;
    assign store.touch       = idle && i_read && store.hit;
    assign store.write_word  = idle && !i_read && i_write && store.hit;
    assign store.install     = (state_q == RESPOND);
    assign store.wdata       = i_wdata;
    assign store.stamp       = idle ? i_instr_count : stamp_q;   // request-time stamp on fill
    assign store.fill_line   = {fill_q[3], fill_q[2], fill_q[1], fill_q[0]};

    assign o_hit   = idle && store.hit;
    assign o_rdata = o_hit ? store.hit_word : resp_q;
    assign o_busy  = !idle;
    assign o_done  = (state_q == RESPOND) || (state_q == WRITE);

    assign o_mem_read  = filling;
    assign o_mem_write = (state_q == WRITE);
    assign o_mem_addr  = filling ? {addr_q[WORD_W-1:OFFSET_W], fill_off} : addr_q;
    assign o_mem_wdata = wdata_q;

endmodule

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int WORD_W         = 16;
    localparam int OFFSET_W       = 2;
    localparam int INDEX_W        = 1;
    localparam int TAG_W          = WORD_W - INDEX_W - OFFSET_W;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 2;
    localparam int NUM_WAYS       = 2;   // victim choice below is two-way only

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WORD_W-1:0]   stamp_t;   // instruction count at last access

    // word 0 in the low bits
    typedef logic [WORDS_PER_LINE*WORD_W-1:0] line_t;

    typedef enum logic [2:0] {
        IDLE,
        FILL0,
        FILL1,
        FILL2,
        FILL3,
        RESPOND,
        WRITE
    } dcache_state_e;

endpackage

// ==== rtl/dcache_store.sv ====
`timescale 1ns/1ps

module dcache_store (
    input  logic           clk,
    input  logic           reset_n,
    dcache_store_if.store  store
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    tag_t   tag_q   [NUM_SETS][NUM_WAYS];
    line_t  line_q  [NUM_SETS][NUM_WAYS];
    stamp_t stamp_q [NUM_SETS][NUM_WAYS];

    tag_t    lk_tag;
    index_t  lk_idx;
    offset_t lk_off;

    logic [NUM_WAYS-1:0] way_hit;
    logic                hit;
    logic                hit_way;
    logic                victim;
    line_t               hit_line;

    // address split
    assign lk_tag = store.lookup_addr[WORD_W-1:OFFSET_W+INDEX_W];
    assign lk_idx = store.lookup_addr[OFFSET_W +: INDEX_W];
    assign lk_off = store.lookup_addr[OFFSET_W-1:0];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[lk_idx][w] && (tag_q[lk_idx][w] == lk_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = !way_hit[0];   // way 0 wins if both match
    assign hit_line = line_q[lk_idx][hit_way];

    assign store.hit      = hit;
    assign store.hit_word = hit_line[lk_off*WORD_W +: WORD_W];

    // invalid way first, then the older stamp
    always_comb begin
        if (!valid_q[lk_idx][0]) begin
            victim = 1'b0;
        end else if (!valid_q[lk_idx][1]) begin
            victim = 1'b1;
        end else if (stamp_q[lk_idx][0] < stamp_q[lk_idx][1]) begin
            victim = 1'b0;
        end else begin
            victim = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q <= '0;
        end else if (store.install) begin
            valid_q[lk_idx][victim] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store.install) begin
            tag_q[lk_idx][victim]   <= lk_tag;
            line_q[lk_idx][victim]  <= store.fill_line;
            stamp_q[lk_idx][victim] <= store.stamp;
        end else if (hit && (store.touch || store.write_word)) begin
            stamp_q[lk_idx][hit_way] <= store.stamp;
            if (store.write_word) begin
                line_q[lk_idx][hit_way][lk_off*WORD_W +: WORD_W] <= store.wdata;
            end
        end
    end

endmodule

// ==== rtl/dcache_store_if.sv ====
`timescale 1ns/1ps

interface dcache_store_if;
    import dcache_pkg::*;

    word_t  lookup_addr;   // live address in idle, captured one otherwise
    logic   touch;
    logic   write_word;
    logic   install;
    word_t  wdata;
    line_t  fill_line;
    stamp_t stamp;

    logic   hit;
    word_t  hit_word;

    modport ctrl (
        output lookup_addr,
        output touch,
        output write_word,
        output install,
        output wdata,
        output fill_line,
        output stamp,
        input  hit,
        input  hit_word
    );

    modport store (
        input  lookup_addr,
        input  touch,
        input  write_word,
        input  install,
        input  wdata,
        input  fill_line,
        input  stamp,
        output hit,
        output hit_word
    );

endinterface

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_read,
    input  logic                i_write,
    input  dcache_pkg::word_t   i_addr,
    input  dcache_pkg::word_t   i_wdata,
    input  dcache_pkg::stamp_t  i_instr_count,
    input  dcache_pkg::word_t   i_mem_rdata,
    output dcache_pkg::word_t   o_rdata,
    output logic                o_hit,
    output logic                o_busy,
    output logic                o_done,
    output dcache_pkg::word_t   o_mem_addr,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output dcache_pkg::word_t   o_mem_wdata
);

    dcache_store_if store_bus ();

    dcache_ctrl ctrl_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .i_instr_count (i_instr_count),
        .i_mem_rdata   (i_mem_rdata),
        .o_rdata       (o_rdata),
        .o_hit         (o_hit),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_mem_addr    (o_mem_addr),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_mem_wdata   (o_mem_wdata),
        .store         (store_bus.ctrl)
    );

    // tag, data and stamp arrays
    dcache_store store_i (
        .clk     (clk),
        .reset_n (reset_n),
        .store   (store_bus.store)
    );

endmodule

// ==== sim.f ====
rtl/dcache_pkg.sv
rtl/dcache_store_if.sv
rtl/dcache_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_sva.sv
tests/tb_dcache.sv

// ==== tests/dcache_mem_model.sv ====
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int ADDR_BITS = 8
) (
    input  logic               clk,
    input  dcache_pkg::word_t  i_addr,
    input  logic               i_write,
    input  dcache_pkg::word_t  i_wdata,
    output dcache_pkg::word_t  o_rdata
);
    import dcache_pkg::*;

    word_t mem [2**ADDR_BITS];

    // every word holds its own address xor 5a5a
    initial begin
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            mem[i] = word_t'(i) ^ 16'h5a5a;
        end
    end

    assign o_rdata = mem[i_addr[ADDR_BITS-1:0]];   // combinational read

    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr[ADDR_BITS-1:0]] <= i_wdata;
        end
    end

endmodule

// ==== tests/dcache_sva.sv ====
`timescale 1ns/1ps

module dcache_sva (
    input logic clk,
    input logic reset_n,
    input logic o_mem_read,
    input logic o_mem_write,
    input logic o_done,
    input logic o_busy
);

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!reset_n)
        !(o_mem_read && o_mem_write))
        else $error("memory read and write strobes high in the same cycle");

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        o_done |=> !o_done)
        else $error("done strobe held longer than one cycle");

    // one line fill is four word reads
    a_fill_len: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(o_mem_read) |-> o_mem_read [*4] ##1 !o_mem_read)
        else $error("memory read strobe did not last exactly four cycles");

    a_idle_after_reset: assert property (@(posedge clk)
        !reset_n |=> !o_busy)
        else $error("busy high in the cycle after reset");

endmodule

// ==== tests/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    typedef enum {OP_READ, OP_WRITE, OP_RESET} op_e;

    localparam int NUM_ROWS       = 14;
    localparam int MEM_BITS       = 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 10 + 50;
    localparam int WAIT_LIMIT     = 10;
    localparam logic [31:0] SEED  = 32'h53a375a8;

    logic clk, reset_n, i_read, i_write;
    logic o_hit, o_busy, o_done, o_mem_read, o_mem_write;
    word_t i_addr, i_wdata, i_mem_rdata, o_rdata, o_mem_addr, o_mem_wdata;
    stamp_t i_instr_count;

    // stimulus table with expected columns from the reference model
    op_e    ops      [NUM_ROWS];
    word_t  addrs    [NUM_ROWS];
    word_t  wdatas   [NUM_ROWS];
    stamp_t counts   [NUM_ROWS];
    logic   exp_hit  [NUM_ROWS];
    word_t  exp_data [NUM_ROWS];
    string  names    [NUM_ROWS];

    bit     ref_valid [NUM_SETS][NUM_WAYS];
    tag_t   ref_tag   [NUM_SETS][NUM_WAYS];
    stamp_t ref_stamp [NUM_SETS][NUM_WAYS];
    word_t  shadow    [2**MEM_BITS];

    int n_rows = 0;
    int error_count = 0;
    int failed_tests = 0;
    int cycle_count = 0;
    int seed_value;

    dcache_top dut_i (
        .clk (clk), .reset_n (reset_n), .i_read (i_read), .i_write (i_write),
        .i_addr (i_addr), .i_wdata (i_wdata), .i_instr_count (i_instr_count),
        .i_mem_rdata (i_mem_rdata), .o_rdata (o_rdata), .o_hit (o_hit),
        .o_busy (o_busy), .o_done (o_done), .o_mem_addr (o_mem_addr),
        .o_mem_read (o_mem_read), .o_mem_write (o_mem_write), .o_mem_wdata (o_mem_wdata)
    );

    dcache_mem_model #(.ADDR_BITS(MEM_BITS)) mem_i (
        .clk (clk), .i_addr (o_mem_addr), .i_write (o_mem_write),
        .i_wdata (o_mem_wdata), .o_rdata (i_mem_rdata)
    );

    bind dcache_top dcache_sva sva_i (
        .clk (clk), .reset_n (reset_n), .o_mem_read (o_mem_read),
        .o_mem_write (o_mem_write), .o_done (o_done), .o_busy (o_busy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic add_row(input op_e op, input word_t addr, input stamp_t cnt, input string nm);
        ops[n_rows]    = op;
        addrs[n_rows]  = addr;
        counts[n_rows] = cnt;
        wdatas[n_rows] = '0;
        names[n_rows]  = nm;
        n_rows++;
    endtask

    task automatic check_value(input string nm, input string what,
                               input logic [WORD_W-1:0] exp, input logic [WORD_W-1:0] act);
        assert (exp === act) else begin
            $display("error %s: %s expected %0h, actual %0h", nm, what, exp, act);
            error_count++;
        end
    endtask

    // write-through cache with lru over a memory shadow
    task automatic predict_expected();
        index_t idx;
        tag_t   tag;
        int     way;
        int     victim;
        for (int i = 0; i < 2**MEM_BITS; i++) shadow[i] = word_t'(i) ^ 16'h5a5a;
        for (int r = 0; r < n_rows; r++) begin
            idx = addrs[r][2];
            tag = addrs[r][15:3];
            way = -1;
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (ref_valid[idx][w] && ref_tag[idx][w] == tag) way = w;
            end
            exp_hit[r] = (way >= 0) && (ops[r] != OP_RESET);
            if (ops[r] == OP_RESET) begin
                foreach (ref_valid[s, w]) ref_valid[s][w] = 0;
            end else if (ops[r] == OP_WRITE) begin
                wdatas[r] = word_t'($urandom);
                shadow[addrs[r][MEM_BITS-1:0]] = wdatas[r];
                exp_data[r] = wdatas[r];
                if (way >= 0) ref_stamp[idx][way] = counts[r];
            end else begin
                exp_data[r] = shadow[addrs[r][MEM_BITS-1:0]];
                if (way >= 0) begin
                    ref_stamp[idx][way] = counts[r];
                end else begin
                    if (!ref_valid[idx][0]) victim = 0;
                    else if (!ref_valid[idx][1]) victim = 1;
                    else if (ref_stamp[idx][0] < ref_stamp[idx][1]) victim = 0;
                    else victim = 1;
                    ref_valid[idx][victim] = 1;
                    ref_tag[idx][victim]   = tag;
                    ref_stamp[idx][victim] = counts[r];
                end
            end
        end
    endtask

    task automatic pulse_reset(input int r);
        @(posedge clk);
        reset_n <= 1'b0;
        i_addr  <= addrs[r];   // a line that was cached before the reset
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value(names[r], "busy", 1'b0, o_busy);
        check_value(names[r], "hit", exp_hit[r], o_hit);
    endtask

    task automatic drive_access(input int r);
        int cycles;
        int reads;
        @(posedge clk);
        i_read        <= (ops[r] == OP_READ);
        i_write       <= (ops[r] == OP_WRITE);
        i_addr        <= addrs[r];
        i_wdata       <= wdatas[r];
        i_instr_count <= counts[r];
        @(negedge clk);
        check_value(names[r], "hit", exp_hit[r], o_hit);
        check_value(names[r], "busy", 1'b0, o_busy);
        if (ops[r] == OP_READ && exp_hit[r]) begin
            check_value(names[r], "rdata", exp_data[r], o_rdata);
        end
        @(posedge clk);
        i_read  <= 1'b0;
        i_write <= 1'b0;
        if (ops[r] == OP_WRITE || !exp_hit[r]) begin
            cycles = 0;
            reads  = 0;
            do begin
                @(negedge clk);
                cycles++;
                check_value(names[r], "busy", 1'b1, o_busy);
                if (o_mem_read) begin
                    check_value(names[r], "fill addr",
                                (addrs[r] & 16'hfffc) + reads, o_mem_addr);
                    reads++;
                end
            end while (!o_done && cycles < WAIT_LIMIT);
            assert (o_done) else begin
                $display("error %s: no done pulse within %0d cycles", names[r], WAIT_LIMIT);
                error_count++;
            end
            if (ops[r] == OP_READ) begin
                check_value(names[r], "done cycle", 5, cycles);
                check_value(names[r], "memory reads", 4, reads);
                check_value(names[r], "rdata", exp_data[r], o_rdata);
                check_value(names[r], "hit at done", 1'b0, o_hit);
            end else begin
                check_value(names[r], "done cycle", 1, cycles);
                check_value(names[r], "memory reads", 0, reads);
                check_value(names[r], "mem write", 1'b1, o_mem_write);
                check_value(names[r], "mem addr", addrs[r], o_mem_addr);
                check_value(names[r], "mem wdata", exp_data[r], o_mem_wdata);
            end
        end else begin
            @(negedge clk);   // a hit leaves the controller idle
            check_value(names[r], "busy after hit", 1'b0, o_busy);
            check_value(names[r], "done after hit", 1'b0, o_done);
        end
    endtask

    initial begin
        int errors_before;
        clk = 1'b0;
        reset_n = 1'b0;
        i_read = 1'b0;
        i_write = 1'b0;
        i_addr = '0;
        i_wdata = '0;
        i_instr_count = '0;
        seed_value = $urandom(SEED);

        // set 0 holds lines 0x00, 0x08, 0x10; 0x25 sits in set 1
        add_row(OP_READ,  16'h0001, 16'd10, "read_miss_fill");
        add_row(OP_READ,  16'h0003, 16'd11, "read_hit_same_line");
        add_row(OP_WRITE, 16'h0002, 16'd12, "write_hit");
        add_row(OP_READ,  16'h0002, 16'd13, "read_after_write_hit");
        add_row(OP_WRITE, 16'h0025, 16'd14, "write_miss_no_alloc");
        add_row(OP_READ,  16'h0025, 16'd15, "read_after_write_miss");
        add_row(OP_READ,  16'h0008, 16'd16, "fill_second_way");
        add_row(OP_READ,  16'h0000, 16'd20, "touch_first_line");
        add_row(OP_READ,  16'h0010, 16'd21, "miss_evicts_lru");
        add_row(OP_READ,  16'h0001, 16'd22, "first_line_kept");
        add_row(OP_READ,  16'h0009, 16'd23, "second_line_evicted");
        add_row(OP_RESET, 16'h0000, 16'd0,  "reset_mid_run");
        add_row(OP_READ,  16'h0003, 16'd24, "miss_after_reset");
        add_row(OP_READ,  16'h0000, 16'd25, "hit_after_refill");
        predict_expected();

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            errors_before = error_count;
            if (ops[r] == OP_RESET) pulse_reset(r);
            else drive_access(r);
            if (error_count == errors_before) begin
                $display("ok    %s", names[r]);
            end else begin
                $display("fail  %s", names[r]);
                failed_tests++;
            end
        end

        $display("tests: %0d, failed: %0d, errors: %0d", n_rows, failed_tests, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
